// File: Makefile
TOOL      := verilator
TOP       := tb_dbg_uart
RTL_TOP   := dbg_uart_top
FLIST     := all.f
LINT_FLAGS := --lint-only -Wall --timescale 1ns/100ps
SIM_FLAGS := --binary --timing --assert --timescale 1ns/100ps
SIM_ARGS  := +verilator+error+limit+1000
PASS_MSG  := all tests passed

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: all.f
+incdir+include
src/dbg_uart_pkg.sv
src/uart_rx.sv
src/uart_tx.sv
src/cmd_detect.sv
src/frame_serializer.sv
src/tx_sequencer.sv
src/dbg_uart_top.sv
verif/dbg_uart_props.sv
verif/tb_dbg_uart.sv

// File: include/dbg_uart_defs.svh
/*
 * debug UART link constants
 * bit timing, frame layout and greeting command bytes
 */
`ifndef DBG_UART_DEFS_SVH
`define DBG_UART_DEFS_SVH

// default clocks per serial bit, 16 MHz at 115200 baud
`define DBG_CLKS_PER_BIT 139

// outgoing debug frame, sync byte included
`define DBG_FRAME_BYTES 8
`define DBG_SYNC_BYTE 8'hFF

// ascii "A" on the rx line requests the greeting
`define DBG_CMD_HELLO 8'h41

// greeting "Hello"
`define DBG_HELLO_LEN 5
`define DBG_HELLO_0 8'h48
`define DBG_HELLO_1 8'h65
`define DBG_HELLO_2 8'h6C
`define DBG_HELLO_3 8'h6C
`define DBG_HELLO_4 8'h6F

`endif

// File: src/cmd_detect.sv
/*
 * greeting command detector
 * sticky request on each received "A", cleared when taken
 */
`include "dbg_uart_defs.svh"

module cmd_detect
  import dbg_uart_pkg::*;
(
  input  logic     clk,
  input  logic     i_arst_n,
  input  rx_byte_t i_rx,
  input  logic     i_hello_take,
  output logic     o_hello_pend
);

  logic w_match;

  // only the newest byte matters
  assign w_match = i_rx.valid && (i_rx.data == `DBG_CMD_HELLO);

  // new match wins over take, so a late "A" is not lost
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
      o_hello_pend <= 1'b0;
    else if (w_match)
      o_hello_pend <= 1'b1;
    else if (i_hello_take)
      o_hello_pend <= 1'b0;
  end

endmodule

// File: src/dbg_uart_pkg.sv
/*
 * debug UART types
 * debug frame layout and received byte bundle
 */
package dbg_uart_pkg;

  // frame as handed over by the host, msb byte goes out first
  // sync byte is not stored, serializer appends it
  typedef struct packed {
    logic [7:0]  custom_cmd;
    logic [7:0]  cmd;
    logic [15:0] data1;
    logic [15:0] data2;
    logic [7:0]  data3;
  } dbg_frame_t;

  // one decoded rx byte
  // valid is a single cycle strobe
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } rx_byte_t;

endpackage

// File: src/dbg_uart_top.sv
/*
 * debug UART link top level
 * frame and greeting transmit path with command receiver
 */
`include "dbg_uart_defs.svh"

module dbg_uart_top
  import dbg_uart_pkg::*;
#(
  parameter int unsigned P_CLKS_PER_BIT = `DBG_CLKS_PER_BIT
) (
  input  logic       clk,
  input  logic       i_arst_n,
  input  dbg_frame_t i_frame,
  input  logic       i_frame_valid,
  input  logic       i_rx,
  output logic       o_tx,
  output logic       o_ready
);

  rx_byte_t   w_rx_byte;
  logic       w_hello_pend;
  logic       w_hello_take;
  logic       w_frame_pend;
  logic [7:0] w_frame_byte;
  logic       w_frame_last;
  logic       w_next;
  logic       w_tx_start;
  logic [7:0] w_tx_byte;
  logic       w_tx_done;
  logic       w_busy;

  assign o_ready = ~w_busy;

  // receive side
  uart_rx #(.P_CLKS_PER_BIT(P_CLKS_PER_BIT)) i_uart_rx (
    .clk(clk), .i_arst_n(i_arst_n), .i_rx(i_rx), .o_rx(w_rx_byte)
  );

  cmd_detect i_cmd_detect (
    .clk(clk), .i_arst_n(i_arst_n), .i_rx(w_rx_byte),
    .i_hello_take(w_hello_take), .o_hello_pend(w_hello_pend)
  );

  // transmit side
  frame_serializer i_frame_serializer (
    .clk(clk), .i_arst_n(i_arst_n), .i_frame(i_frame),
    .i_frame_valid(i_frame_valid), .i_busy(w_busy), .i_next(w_next),
    .o_frame_pend(w_frame_pend), .o_byte(w_frame_byte), .o_last(w_frame_last)
  );

  tx_sequencer i_tx_sequencer (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_frame_pend(w_frame_pend), .i_frame_byte(w_frame_byte),
    .i_frame_last(w_frame_last), .i_hello_pend(w_hello_pend),
    .i_tx_done(w_tx_done), .o_next(w_next), .o_hello_take(w_hello_take),
    .o_tx_start(w_tx_start), .o_tx_byte(w_tx_byte), .o_busy(w_busy)
  );

  uart_tx #(.P_CLKS_PER_BIT(P_CLKS_PER_BIT)) i_uart_tx (
    .clk(clk), .i_arst_n(i_arst_n), .i_start(w_tx_start),
    .i_byte(w_tx_byte), .o_tx(o_tx), .o_done(w_tx_done)
  );

endmodule

// File: src/frame_serializer.sv
/*
 * debug frame serializer
 * latches one frame and presents its bytes msb first, sync byte last
 */
`include "dbg_uart_defs.svh"

module frame_serializer
  import dbg_uart_pkg::*;
(
  input  logic       clk,
  input  logic       i_arst_n,
  input  dbg_frame_t i_frame,
  input  logic       i_frame_valid,
  input  logic       i_busy,
  input  logic       i_next,
  output logic       o_frame_pend,
  output logic [7:0] o_byte,
  output logic       o_last
);

  dbg_frame_t r_frame;
  logic [2:0] r_idx;
  logic       w_accept;

  // strobe while busy is simply dropped
  assign w_accept = i_frame_valid && !i_busy;
  assign o_last   = (r_idx == 3'(`DBG_FRAME_BYTES - 1));

  always_ff @(posedge clk)
  begin
    if (w_accept)
      r_frame <= i_frame;
  end

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_frame_pend <= 1'b0;
      r_idx        <= '0;
    end
    else if (w_accept)
    begin
      o_frame_pend <= 1'b1;
      r_idx        <= '0;
    end
    else if (i_next)
    begin
      r_idx <= o_last ? '0 : r_idx + 1'b1;
      if (o_last)
        o_frame_pend <= 1'b0;
    end
  end

  // byte select, data words high byte first
  always_comb
  begin
    case (r_idx)
      3'd0:    o_byte = r_frame.custom_cmd;
      3'd1:    o_byte = r_frame.cmd;
      3'd2:    o_byte = r_frame.data1[15:8];
      3'd3:    o_byte = r_frame.data1[7:0];
      3'd4:    o_byte = r_frame.data2[15:8];
      3'd5:    o_byte = r_frame.data2[7:0];
      3'd6:    o_byte = r_frame.data3;
      default: o_byte = `DBG_SYNC_BYTE;
    endcase
  end

endmodule

// File: src/tx_sequencer.sv
/*
 * transmit sequencer
 * picks frame or greeting bytes and paces the UART transmitter
 */
`include "dbg_uart_defs.svh"

module tx_sequencer (
  input  logic       clk,
  input  logic       i_arst_n,
  input  logic       i_frame_pend,
  input  logic [7:0] i_frame_byte,
  input  logic       i_frame_last,
  input  logic       i_hello_pend,
  input  logic       i_tx_done,
  output logic       o_next,
  output logic       o_hello_take,
  output logic       o_tx_start,
  output logic [7:0] o_tx_byte,
  output logic       o_busy
);

  typedef enum logic [1:0] {S_IDLE, S_FRAME, S_HELLO} state_t;

  state_t     r_state;
  logic [2:0] r_letter;
  logic       r_inflight;
  logic       r_gap;
  logic [7:0] w_letter;

  ////////////////////////////////////////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////////////////////////////////////////

  // frame first, greeting only from idle
  assign o_hello_take = (r_state == S_IDLE) && !i_frame_pend && i_hello_pend;
  assign o_next       = (r_state == S_FRAME) && i_tx_done;
  // r_gap skips the transmitter's cleanup cycle
  assign o_tx_start   = (r_state != S_IDLE) && !r_inflight && !r_gap;
  assign o_busy       = (r_state != S_IDLE) || i_frame_pend || i_hello_pend;
  assign o_tx_byte    = (r_state == S_HELLO) ? w_letter : i_frame_byte;

  always_comb
  begin
    case (r_letter)
      3'd0:    w_letter = `DBG_HELLO_0;
      3'd1:    w_letter = `DBG_HELLO_1;
      3'd2:    w_letter = `DBG_HELLO_2;
      3'd3:    w_letter = `DBG_HELLO_3;
      default: w_letter = `DBG_HELLO_4;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // source select FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      r_state    <= S_IDLE;
      r_letter   <= '0;
      r_inflight <= 1'b0;
      r_gap      <= 1'b0;
    end
    else
    begin
      r_gap <= i_tx_done;
      if (o_tx_start)
        r_inflight <= 1'b1;
      else if (i_tx_done)
        r_inflight <= 1'b0;
      case (r_state)
        S_IDLE:
        begin
          r_letter <= '0;
          if (i_frame_pend)
            r_state <= S_FRAME;
          else if (i_hello_pend)
            r_state <= S_HELLO;
        end
        // frame ends on done of the sync byte
        S_FRAME: if (i_tx_done && i_frame_last) r_state <= S_IDLE;
        S_HELLO:
        begin
          if (i_tx_done)
          begin
            r_letter <= r_letter + 1'b1;
            if (r_letter == 3'(`DBG_HELLO_LEN - 1))
              r_state <= S_IDLE;
          end
        end
        default: r_state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: src/uart_rx.sv
/*
 * UART receiver, 8N1
 * two-flop input sync, mid-bit sampling, stop bit check
 */
`include "dbg_uart_defs.svh"

module uart_rx
  import dbg_uart_pkg::*;
#(
  parameter int unsigned P_CLKS_PER_BIT = `DBG_CLKS_PER_BIT
) (
  input  logic     clk,
  input  logic     i_arst_n,
  input  logic     i_rx,
  output rx_byte_t o_rx
);

  localparam int unsigned CW   = $clog2(P_CLKS_PER_BIT);
  localparam int unsigned LAST = P_CLKS_PER_BIT - 1;
  localparam int unsigned HALF = (P_CLKS_PER_BIT - 1) / 2;

  typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

  state_t        r_state;
  logic [CW-1:0] r_cnt;
  logic [2:0]    r_bit;
  logic [7:0]    r_shift;
  logic          r_sync1;
  logic          r_sync2;

  // line idles high, so sync flops reset to 1
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      r_sync1 <= 1'b1;
      r_sync2 <= 1'b1;
    end
    else
    begin
      r_sync1 <= i_rx;
      r_sync2 <= r_sync1;
    end
  end

  // data shifts in lsb first, msb ends up at bit 7
  always_ff @(posedge clk)
  begin
    if (r_state == S_DATA && r_cnt == CW'(LAST))
      r_shift <= {r_sync2, r_shift[7:1]};
  end

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      r_state <= S_IDLE;
      r_cnt   <= '0;
      r_bit   <= '0;
      o_rx    <= '0;
    end
    else
    begin
      o_rx.valid <= 1'b0;
      case (r_state)
        S_IDLE:
        begin
          r_cnt <= '0;
          r_bit <= '0;
          if (!r_sync2)
            r_state <= S_START;
        end
        // half a bit in, start bit must still be low
        S_START:
        begin
          if (r_cnt == CW'(HALF))
          begin
            r_cnt   <= '0;
            r_state <= r_sync2 ? S_IDLE : S_DATA;
          end
          else
            r_cnt <= r_cnt + 1'b1;
        end
        // full bit steps keep us at mid-bit
        S_DATA:
        begin
          if (r_cnt == CW'(LAST))
          begin
            r_cnt <= '0;
            r_bit <= r_bit + 1'b1;
            if (r_bit == 3'd7)
              r_state <= S_STOP;
          end
          else
            r_cnt <= r_cnt + 1'b1;
        end
        // mid stop bit, drop the byte on a framing error
        S_STOP:
        begin
          if (r_cnt == CW'(LAST))
          begin
            r_cnt      <= '0;
            r_state    <= S_IDLE;
            o_rx.valid <= r_sync2;
            o_rx.data  <= r_shift;
          end
          else
            r_cnt <= r_cnt + 1'b1;
        end
        default: r_state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: src/uart_tx.sv
/*
 * UART transmitter, 8N1
 * one byte per start strobe, done pulses in the last stop bit cycle
 */
`include "dbg_uart_defs.svh"

module uart_tx #(
  parameter int unsigned P_CLKS_PER_BIT = `DBG_CLKS_PER_BIT
) (
  input  logic       clk,
  input  logic       i_arst_n,
  input  logic       i_start,
  input  logic [7:0] i_byte,
  output logic       o_tx,
  output logic       o_done
);

  localparam int unsigned CW   = $clog2(P_CLKS_PER_BIT);
  localparam int unsigned LAST = P_CLKS_PER_BIT - 1;

  typedef enum logic [2:0] {S_IDLE, S_START, S_DATA, S_STOP, S_CLEANUP} state_t;

  state_t        r_state;
  logic [CW-1:0] r_cnt;
  logic [2:0]    r_bit;
  logic [7:0]    r_shift;
  logic          w_bit_end;

  assign w_bit_end = (r_cnt == CW'(LAST));

  // line level straight from state, lsb of shifter during data
  always_comb
  begin
    case (r_state)
      S_START: o_tx = 1'b0;
      S_DATA:  o_tx = r_shift[0];
      default: o_tx = 1'b1;
    endcase
  end

  assign o_done = (r_state == S_STOP) && w_bit_end;

  always_ff @(posedge clk)
  begin
    if (r_state == S_IDLE && i_start)
      r_shift <= i_byte;
    else if (r_state == S_DATA && w_bit_end)
      r_shift <= {1'b1, r_shift[7:1]};
  end

  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      r_state <= S_IDLE;
      r_cnt   <= '0;
      r_bit   <= '0;
    end
    else
    begin
      r_cnt <= w_bit_end ? '0 : r_cnt + 1'b1;
      case (r_state)
        S_IDLE:
        begin
          r_cnt <= '0;
          r_bit <= '0;
          if (i_start)
            r_state <= S_START;
        end
        S_START: if (w_bit_end) r_state <= S_DATA;
        S_DATA:
        begin
          if (w_bit_end)
          begin
            r_bit <= r_bit + 1'b1;
            if (r_bit == 3'd7)
              r_state <= S_STOP;
          end
        end
        S_STOP: if (w_bit_end) r_state <= S_CLEANUP;
        // one spare cycle before the next byte
        default: r_state <= S_IDLE;
      endcase
    end
  end

endmodule

// File: verif/dbg_uart_props.sv
/*
 * debug UART link properties
 * idle line, ready handshake and reset behavior of the top level
 */
module dbg_uart_props (
  input logic clk,
  input logic i_arst_n,
  input logic i_frame_valid,
  input logic i_tx,
  input logic i_ready
);

  timeunit 1ns;
  timeprecision 100ps;

  // number of failed property checks, read by the testbench
  int unsigned fail_count = 0;

  // nothing pending means the line sits idle
  a_idle_line: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_ready |-> i_tx)
  else
  begin
    $error("o_tx low while o_ready is high");
    fail_count++;
  end

  // accepted strobe makes the link busy on the next cycle
  a_ready_falls: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_frame_valid && i_ready) |=> !i_ready)
  else
  begin
    $error("o_ready still high after an accepted frame strobe");
    fail_count++;
  end

  a_tx_known: assert property (@(posedge clk) disable iff (!i_arst_n)
    !$isunknown(i_tx))
  else
  begin
    $error("o_tx is unknown after reset");
    fail_count++;
  end

  // first clock after reset release
  a_ready_after_reset: assert property (@(posedge clk)
    $rose(i_arst_n) |-> i_ready)
  else
  begin
    $error("o_ready low in the first cycle after reset");
    fail_count++;
  end

endmodule

bind dbg_uart_top dbg_uart_props i_dbg_uart_props (
  .clk(clk),
  .i_arst_n(i_arst_n),
  .i_frame_valid(i_frame_valid),
  .i_tx(o_tx),
  .i_ready(o_ready)
);

// File: verif/tb_dbg_uart.sv
/*
 * testbench for the debug UART link
 * drives frames and rx bytes, decodes the tx line, compares byte streams
 */
module tb_dbg_uart
  import dbg_uart_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  // 8 clocks per bit at 8 ns per clock
  localparam int unsigned CLKS_PER_BIT = 8;
  localparam int unsigned BIT_NS       = CLKS_PER_BIT * 8;
  // half a bit plus half a clock, away from any edge
  localparam int unsigned SAMPLE_NS    = BIT_NS / 2 + 4;
  // 4 frames and 2 greetings
  localparam int unsigned TOTAL_BYTES  = 42;
  localparam int unsigned LIMIT        = 2 * TOTAL_BYTES * 10 * CLKS_PER_BIT + 1500;

  logic       clk;
  logic       i_arst_n;
  dbg_frame_t i_frame;
  logic       i_frame_valid;
  logic       i_rx;
  logic       o_tx;
  logic       o_ready;

  logic [7:0]  got_q[$];
  logic [7:0]  exp_q[$];
  logic        mon_busy = 1'b0;
  logic [31:0] lfsr_state = 32'h2fbe;
  int unsigned n_err = 0;
  int unsigned n_tests = 0;
  int unsigned n_failed = 0;
  int unsigned cycles = 0;

  dbg_uart_top #(.P_CLKS_PER_BIT(CLKS_PER_BIT)) i_dbg_uart_top (
    .clk(clk), .i_arst_n(i_arst_n), .i_frame(i_frame),
    .i_frame_valid(i_frame_valid), .i_rx(i_rx), .o_tx(o_tx), .o_ready(o_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // run limit from total byte count
  always @(posedge clk)
  begin
    cycles++;
    if (cycles == LIMIT)
    begin
      $display("timeout: run did not finish");
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // random data and expected streams
  ////////////////////////////////////////////////////////////////////////////

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    for (int i = 0; i < 8; i++)
      b[i] = lfsr_bit();
    return b;
  endfunction

  function automatic dbg_frame_t rand_frame();
    dbg_frame_t f;
    f.custom_cmd = rand_byte();
    f.cmd        = rand_byte();
    f.data1      = {rand_byte(), rand_byte()};
    f.data2      = {rand_byte(), rand_byte()};
    f.data3      = rand_byte();
    return f;
  endfunction

  // wire order: custom, cmd, words high byte first, data3, sync
  task automatic push_frame(input dbg_frame_t f);
    exp_q.push_back(f.custom_cmd);
    exp_q.push_back(f.cmd);
    exp_q.push_back(f.data1[15:8]);
    exp_q.push_back(f.data1[7:0]);
    exp_q.push_back(f.data2[15:8]);
    exp_q.push_back(f.data2[7:0]);
    exp_q.push_back(f.data3);
    exp_q.push_back(8'hFF);
  endtask

  task automatic push_hello();
    string s;
    s = "Hello";
    for (int i = 0; i < s.len(); i++)
      exp_q.push_back(s[i]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // drivers and line monitor
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_frame(input dbg_frame_t f);
    @(posedge clk);
    #1;
    i_frame       = f;
    i_frame_valid = 1'b1;
    @(posedge clk);
    #1;
    i_frame_valid = 1'b0;
  endtask

  // holds each level for one full bit
  task automatic drive_bit(input logic v);
    @(posedge clk);
    #1;
    i_rx = v;
    repeat (CLKS_PER_BIT - 1) @(posedge clk);
  endtask

  // 8N1, lsb first
  task automatic send_serial(input logic [7:0] b);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++)
      drive_bit(b[i]);
    drive_bit(1'b1);
  endtask

  // let the link go busy, then wait for ready and a quiet monitor
  task automatic wait_done();
    repeat (2) @(negedge clk);
    while (!(o_ready && !mon_busy))
      @(negedge clk);
  endtask

  initial
  begin
    logic [7:0] v;
    wait (i_arst_n === 1'b1);
    forever
    begin
      @(negedge o_tx);
      mon_busy = 1'b1;
      #(SAMPLE_NS);
      assert (o_tx === 1'b0)
      else
      begin
        $error("CHECK FAILED at %0t: start bit not low at mid-bit", $time);
        n_err++;
      end
      for (int i = 0; i < 8; i++)
      begin
        #(BIT_NS);
        v[i] = o_tx;
      end
      #(BIT_NS);
      assert (o_tx === 1'b1)
      else
      begin
        $error("CHECK FAILED at %0t: stop bit not high", $time);
        n_err++;
      end
      got_q.push_back(v);
      mon_busy = 1'b0;
    end
  end

  // compare streams, one line per test
  task automatic finish_test(input string name);
    int unsigned err_before;
    int unsigned n;
    err_before = n_err;
    assert (got_q.size() == exp_q.size())
    else
    begin
      $error("CHECK FAILED at %0t: %s got %0d bytes, expected %0d",
             $time, name, got_q.size(), exp_q.size());
      n_err++;
    end
    n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
    for (int i = 0; i < n; i++)
    begin
      assert (got_q[i] === exp_q[i])
      else
      begin
        $error("CHECK FAILED at %0t: %s byte %0d is %h, expected %h",
               $time, name, i, got_q[i], exp_q[i]);
        n_err++;
      end
    end
    n_tests++;
    if (n_err != err_before)
    begin
      n_failed++;
      $display("test %s: FAIL", name);
    end
    else
      $display("test %s: ok", name);
    got_q.delete();
    exp_q.delete();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    dbg_frame_t fa;
    dbg_frame_t fb;
    i_arst_n      = 1'b0;
    i_rx          = 1'b1;
    i_frame       = '0;
    i_frame_valid = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    i_arst_n = 1'b1;

    // quiet line after reset
    @(negedge clk);
    assert (o_tx === 1'b1 && o_ready === 1'b1)
    else
    begin
      $error("CHECK FAILED at %0t: o_tx or o_ready not high after reset", $time);
      n_err++;
    end
    repeat (100) @(negedge clk);
    finish_test("idle_after_reset");

    fa = rand_frame();
    send_frame(fa);
    push_frame(fa);
    wait_done();
    finish_test("one_frame");

    // second strobe lands while busy
    fa = rand_frame();
    fb = rand_frame();
    send_frame(fa);
    push_frame(fa);
    repeat (20) @(negedge clk);
    assert (o_ready === 1'b0)
    else
    begin
      $error("CHECK FAILED at %0t: o_ready high during a frame", $time);
      n_err++;
    end
    send_frame(fb);
    wait_done();
    finish_test("busy_strobe_ignored");
    send_frame(fb);
    push_frame(fb);
    wait_done();
    finish_test("frame_after_ready");

    send_serial(8'h41);
    push_hello();
    wait_done();
    finish_test("hello_on_a");

    // near misses of the command byte
    send_serial(8'h61);
    send_serial(8'h40);
    repeat (100) @(negedge clk);
    wait_done();
    finish_test("other_byte_ignored");

    // greeting queued behind a running frame
    fa = rand_frame();
    send_frame(fa);
    push_frame(fa);
    push_hello();
    repeat (100) @(posedge clk);
    send_serial(8'h41);
    wait_done();
    finish_test("hello_after_frame");

    $display("tests run %0d, failing %0d, check errors %0d, property errors %0d",
             n_tests, n_failed, n_err, i_dbg_uart_top.i_dbg_uart_props.fail_count);
    if (n_err == 0 && n_failed == 0 && i_dbg_uart_top.i_dbg_uart_props.fail_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule
